// ==== mem_types_pkg.sv ====
`default_nettype none

package mem_types_pkg;

  // byte address or data word
  typedef logic [31:0] word_t;

  // ram status as seen by the controller
  typedef enum logic [1:0] {
    FREE   = 2'd0,
    BUSY   = 2'd1,
    ACCESS = 2'd2,
    ERROR  = 2'd3
  } ramstate_t;

  // coherence controller states
  typedef enum logic [3:0] {
    IDLE    = 4'd0,
    // snoop cycles
    PRRD    = 4'd1,
    PRWR    = 4'd2,
    // block from ram
    BUSRD1  = 4'd3,
    BUSRD2  = 4'd4,
    // block from peer, ram updated too
    BUSWB1  = 4'd5,
    BUSWB2  = 4'd6,
    // write miss, block from ram
    BUSRDX1 = 4'd7,
    BUSRDX2 = 4'd8,
    // write miss, block from peer only
    BUSWBX1 = 4'd9,
    BUSWBX2 = 4'd10,
    IMEM    = 4'd11,
    CACWB   = 4'd12
  } mc_state_t;

  // one core toward the controller
  typedef struct packed {
    logic  iren;
    logic  dren;
    logic  dwen;
    word_t iaddr;
    word_t daddr;
    word_t dstore;
    // snooped block is modified here, or this core is write missing
    logic  ccwrite;
    // line state change in progress
    logic  cctrans;
  } core_req_t;

  // controller toward one core
  typedef struct packed {
    logic  iwait;
    logic  dwait;
    word_t iload;
    word_t dload;
    logic  ccwait;
    logic  ccinv;
    word_t ccsnoopaddr;
  } core_rsp_t;

  // single ram port
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } ram_req_t;

  // registered controller inputs
  typedef struct packed {
    core_req_t [1:0] req;
    word_t           ramload;
    ramstate_t       ramstate;
  } mc_latch_t;

endpackage

`default_nettype wire

// ==== main_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module main_ram #(
  parameter int RAM_LATENCY   = 2,
  parameter int RAM_ADDR_BITS = 8
) (
  input  wire logic                     CLK,
  input  wire logic                     nRST,
  input  wire mem_types_pkg::ram_req_t  ram_req,
  output mem_types_pkg::word_t          ramload,
  output mem_types_pkg::ramstate_t      ramstate
);

  // wide enough for RAM_LATENCY - 1
  localparam int CW = (RAM_LATENCY > 1) ? $clog2(RAM_LATENCY) : 1;

  mem_types_pkg::word_t mem [2**RAM_ADDR_BITS];

  logic [RAM_ADDR_BITS-1:0] idx;
  logic [CW-1:0]            cnt;
  logic                     active;
  logic                     restart;
  // access already served for this request
  logic                     done;
  logic                     last_ren;
  logic                     last_wen;
  mem_types_pkg::word_t     last_addr;

  // byte address in, word index out
  assign idx    = ram_req.addr[RAM_ADDR_BITS+1:2];
  assign active = ram_req.ren | ram_req.wen;

  // new request edge or new address
  assign restart = active & ((ram_req.ren & ~last_ren) | (ram_req.wen & ~last_wen) |
                             (ram_req.addr != last_addr));

  always_comb begin
    if (ram_req.ren && ram_req.wen) begin
      ramstate = mem_types_pkg::ERROR;
    end else if (!active) begin
      ramstate = mem_types_pkg::FREE;
    end else if (restart || done || (cnt != '0)) begin
      ramstate = mem_types_pkg::BUSY;
    end else begin
      // single access cycle per request
      ramstate = mem_types_pkg::ACCESS;
    end
  end

  assign ramload = (ramstate == mem_types_pkg::ACCESS && ram_req.ren) ? mem[idx] : '0;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt       <= '0;
      done      <= 1'b0;
      last_ren  <= 1'b0;
      last_wen  <= 1'b0;
      last_addr <= '0;
    end else begin
      last_ren  <= ram_req.ren;
      last_wen  <= ram_req.wen;
      last_addr <= ram_req.addr;
      // restart cycle counts as the first busy cycle
      if (restart) begin
        cnt  <= CW'(RAM_LATENCY - 1);
        done <= 1'b0;
      end else if (ramstate == mem_types_pkg::ACCESS) begin
        done <= 1'b1;
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // write lands at the end of the access cycle
  always_ff @(posedge CLK) begin
    if (ramstate == mem_types_pkg::ACCESS && ram_req.wen) begin
      mem[idx] <= ram_req.store;
    end
  end

  // access only after a held request on a steady address
  a_access_req: assert property (@(posedge CLK) disable iff (!nRST)
    (ramstate == mem_types_pkg::ACCESS) |-> active && $past(active) && $stable(ram_req.addr));

endmodule

`default_nettype wire

// ==== memory_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_control (
  input  wire logic                           CLK,
  input  wire logic                           nRST,
  input  wire mem_types_pkg::core_req_t [1:0] req,
  input  wire mem_types_pkg::word_t           ramload,
  input  wire mem_types_pkg::ramstate_t       ramstate,
  output mem_types_pkg::core_rsp_t [1:0]      rsp,
  output mem_types_pkg::ram_req_t             ram_req
);

  // inputs one cycle late
  mem_types_pkg::mc_latch_t mc;
  mem_types_pkg::mc_state_t state;
  mem_types_pkg::mc_state_t next_state;
  // core currently owning the bus
  logic arb;
  logic next_arb;
  // first idle cycle after a transfer, latch still shows the old request
  logic settle;

  mem_types_pkg::core_req_t cur;
  mem_types_pkg::core_req_t oth;
  logic access;
  logic frozen;
  logic tcore;
  logic cur_req;
  logic oth_req;

  assign cur     = mc.req[arb];
  assign oth     = mc.req[~arb];
  assign access  = (mc.ramstate == mem_types_pkg::ACCESS);
  assign frozen  = mc.req[0].cctrans | mc.req[1].cctrans;
  // core 0 wins if both change state
  assign tcore   = ~mc.req[0].cctrans;
  assign cur_req = cur.iren | cur.dren | cur.dwen;
  assign oth_req = oth.iren | oth.dren | oth.dwen;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state  <= mem_types_pkg::IDLE;
      mc     <= '0;
      arb    <= 1'b0;
      settle <= 1'b0;
    end else begin
      state       <= next_state;
      mc.req      <= req;
      mc.ramload  <= ramload;
      mc.ramstate <= ramstate;
      arb         <= next_arb;
      settle      <= (state != mem_types_pkg::IDLE) && (next_state == mem_types_pkg::IDLE);
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      mem_types_pkg::IDLE: begin
        // data side before fetches
        if (!settle) begin
          if (cur.dren && !cur.ccwrite) begin
            next_state = mem_types_pkg::PRRD;
          end else if (cur.dwen && !cur.ccwrite) begin
            next_state = mem_types_pkg::CACWB;
          end else if (cur.dwen && cur.ccwrite) begin
            next_state = mem_types_pkg::PRWR;
          end else if (cur.iren) begin
            next_state = mem_types_pkg::IMEM;
          end
        end
      end
      // peer answers the snoop through its ccwrite
      mem_types_pkg::PRRD: begin
        next_state = oth.ccwrite ? mem_types_pkg::BUSWB1 : mem_types_pkg::BUSRD1;
      end
      mem_types_pkg::PRWR: begin
        next_state = oth.ccwrite ? mem_types_pkg::BUSWBX1 : mem_types_pkg::BUSRDX1;
      end
      // ram paced words
      mem_types_pkg::BUSRD1: if (access) next_state = mem_types_pkg::BUSRD2;
      mem_types_pkg::BUSWB1: if (access) next_state = mem_types_pkg::BUSWB2;
      mem_types_pkg::BUSRDX1: if (access) next_state = mem_types_pkg::BUSRDX2;
      mem_types_pkg::BUSRD2,
      mem_types_pkg::BUSWB2,
      mem_types_pkg::BUSRDX2,
      mem_types_pkg::IMEM,
      mem_types_pkg::CACWB: if (access) next_state = mem_types_pkg::IDLE;
      // peer data, no ram wait
      mem_types_pkg::BUSWBX1: next_state = mem_types_pkg::BUSWBX2;
      mem_types_pkg::BUSWBX2: next_state = mem_types_pkg::IDLE;
      default: next_state = mem_types_pkg::IDLE;
    endcase
    // hold everything while a line changes state
    if (frozen) begin
      next_state = state;
    end
  end

  always_comb begin
    // all waits high, nothing on the bus
    rsp     = '0;
    ram_req = '0;
    for (int i = 0; i < 2; i++) begin
      rsp[i].iwait = 1'b1;
      rsp[i].dwait = 1'b1;
    end

    if (frozen) begin
      rsp[~tcore].ccwait      = 1'b1;
      rsp[~tcore].ccinv       = 1'b1;
      rsp[~tcore].ccsnoopaddr = mc.req[tcore].daddr;
    end else begin
      case (state)
        mem_types_pkg::PRRD,
        mem_types_pkg::PRWR: begin
          rsp[~arb].ccwait      = 1'b1;
          rsp[~arb].ccsnoopaddr = cur.daddr;
        end
        mem_types_pkg::BUSRD1,
        mem_types_pkg::BUSRD2: begin
          rsp[arb].dwait = ~access;
          rsp[arb].dload = mc.ramload;
          ram_req.ren    = 1'b1;
          ram_req.addr   = cur.daddr;
        end
        mem_types_pkg::BUSWB1,
        mem_types_pkg::BUSWB2: begin
          // forward peer word and copy it back to ram
          rsp[arb].dwait        = ~access;
          rsp[arb].dload        = oth.dstore;
          ram_req.wen           = 1'b1;
          ram_req.addr          = cur.daddr;
          ram_req.store         = oth.dstore;
          rsp[~arb].ccwait      = 1'b1;
          rsp[~arb].ccsnoopaddr = cur.daddr;
        end
        mem_types_pkg::BUSRDX1,
        mem_types_pkg::BUSRDX2: begin
          rsp[arb].dwait        = ~access;
          rsp[arb].dload        = mc.ramload;
          ram_req.ren           = 1'b1;
          ram_req.addr          = cur.daddr;
          rsp[~arb].ccwait      = 1'b1;
          rsp[~arb].ccsnoopaddr = cur.daddr;
          // invalidate peer with the last word
          rsp[~arb].ccinv       = (state == mem_types_pkg::BUSRDX2);
        end
        mem_types_pkg::BUSWBX1: begin
          rsp[arb].dwait        = 1'b0;
          rsp[arb].dload        = oth.dstore;
          rsp[~arb].ccwait      = 1'b1;
          rsp[~arb].ccsnoopaddr = cur.daddr;
        end
        mem_types_pkg::BUSWBX2: begin
          // peer already stepped to word two, latch has not caught up
          rsp[arb].dwait        = 1'b0;
          rsp[arb].dload        = req[~arb].dstore;
          rsp[~arb].ccwait      = 1'b1;
          rsp[~arb].ccinv       = 1'b1;
          rsp[~arb].ccsnoopaddr = cur.daddr;
        end
        mem_types_pkg::IMEM: begin
          rsp[arb].iwait = ~access;
          rsp[arb].iload = mc.ramload;
          ram_req.ren    = 1'b1;
          ram_req.addr   = cur.iaddr;
        end
        mem_types_pkg::CACWB: begin
          rsp[arb].dwait        = ~access;
          ram_req.wen           = 1'b1;
          ram_req.addr          = cur.daddr;
          ram_req.store         = cur.dstore;
          rsp[~arb].ccwait      = 1'b1;
          rsp[~arb].ccinv       = 1'b1;
          rsp[~arb].ccsnoopaddr = cur.daddr;
        end
        default: begin
        end
      endcase
    end
  end

  // owner keeps the bus while it asks for anything
  always_comb begin
    next_arb = arb;
    if (state == mem_types_pkg::IDLE && next_state == mem_types_pkg::IDLE) begin
      if (!cur_req && oth_req) begin
        next_arb = ~arb;
      end
    end
  end

  // one ram port, read and write never together
  a_ram_rw: assert property (@(posedge CLK) disable iff (!nRST)
    !(ram_req.ren && ram_req.wen));

  // invalidation only reaches a stalled core
  a_inv_wait: assert property (@(posedge CLK) disable iff (!nRST)
    (!rsp[0].ccinv || rsp[0].ccwait) && (!rsp[1].ccinv || rsp[1].ccwait));

  // data words complete for one core at a time
  a_dwait_one: assert property (@(posedge CLK) disable iff (!nRST)
    rsp[0].dwait || rsp[1].dwait);

endmodule

`default_nettype wire

// ==== memory_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_subsystem #(
  parameter int RAM_LATENCY   = 2,
  parameter int RAM_ADDR_BITS = 8
) (
  input  wire logic                           CLK,
  input  wire logic                           nRST,
  input  wire mem_types_pkg::core_req_t [1:0] req,
  output mem_types_pkg::core_rsp_t [1:0]      rsp
);

  // controller to ram
  wire mem_types_pkg::ram_req_t  ram_req;
  wire mem_types_pkg::word_t     ramload;
  wire mem_types_pkg::ramstate_t ramstate;

  // coherence and arbitration for both cores
  memory_control u_mc (
    .CLK      (CLK),
    .nRST     (nRST),
    .req      (req),
    .ramload  (ramload),
    .ramstate (ramstate),
    .rsp      (rsp),
    .ram_req  (ram_req)
  );

  main_ram #(
    .RAM_LATENCY   (RAM_LATENCY),
    .RAM_ADDR_BITS (RAM_ADDR_BITS)
  ) u_ram (
    .CLK      (CLK),
    .nRST     (nRST),
    .ram_req  (ram_req),
    .ramload  (ramload),
    .ramstate (ramstate)
  );

endmodule

`default_nettype wire

// ==== tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// data words, fetched words and snoop addresses
task automatic check_word(input string name, input mem_types_pkg::word_t exp,
                          input mem_types_pkg::word_t act);
  if (act !== exp) begin
    $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    $display("** FAIL **");
    $fatal(1, "word mismatch in %s", name);
  end
endtask

// single response bits such as waits and coherence flags
task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    $display("** FAIL **");
    $fatal(1, "flag mismatch in %s", name);
  end
endtask

task automatic give_up(input string what);
  $display("%s: %s did not go low within %0d cycles", test_name, what, WAIT_LIMIT);
  $display("** FAIL **");
  $fatal(1, "wait timed out");
endtask

// inputs change a little after the rising edge
task automatic next_drive();
  @(posedge CLK);
  #5;
endtask

// what the idle core sees while core c moves data
task automatic note_peer(input int c);
  if (rsp[1-c].ccwait && !snoop_seen) begin
    snoop_seen  = 1'b1;
    snoop_first = rsp[1-c].ccsnoopaddr;
  end
  if (rsp[1-c].ccinv) begin
    inv_seen = 1'b1;
  end
endtask

// responses sampled on the falling edge
task automatic wait_dwait_low(input int c);
  int n;
  n = 0;
  @(negedge CLK);
  note_peer(c);
  while (rsp[c].dwait) begin
    n++;
    if (n > WAIT_LIMIT) begin
      give_up($sformatf("dwait of core %0d", c));
    end
    @(negedge CLK);
    note_peer(c);
  end
endtask

task automatic wait_iwait_low(input int c);
  int n;
  n = 0;
  @(negedge CLK);
  while (rsp[c].iwait) begin
    n++;
    if (n > WAIT_LIMIT) begin
      give_up($sformatf("iwait of core %0d", c));
    end
    @(negedge CLK);
  end
endtask

// either fetch finishing
task automatic wait_any_iwait();
  int n;
  n = 0;
  @(negedge CLK);
  while (rsp[0].iwait && rsp[1].iwait) begin
    n++;
    if (n > WAIT_LIMIT) begin
      give_up("iwait of both cores");
    end
    @(negedge CLK);
  end
endtask

`endif

// ==== tb_memory_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_memory_subsystem;

  // cycles any single wait may take
  localparam int WAIT_LIMIT = 60;
  // frozen cycles checked during a transition
  localparam int TRANS_HOLD = 6;

  logic CLK;
  logic nRST;
  mem_types_pkg::core_req_t [1:0] req;
  mem_types_pkg::core_rsp_t [1:0] rsp;

  string test_name;
  logic snoop_seen;
  logic inv_seen;
  mem_types_pkg::word_t snoop_first;

  memory_subsystem #(
    .RAM_LATENCY   (2),
    .RAM_ADDR_BITS (8)
  ) u_dut (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (req),
    .rsp  (rsp)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  task automatic apply_reset();
    nRST = 1'b0;
    req  = '0;
    repeat (3) @(posedge CLK);
    #5;
    nRST = 1'b1;
  endtask

  task automatic run_fetch(input int c, input mem_types_pkg::word_t a,
                           output mem_types_pkg::word_t got);
    req[c].iren  = 1'b1;
    req[c].iaddr = a;
    wait_iwait_low(c);
    got = rsp[c].iload;
    next_drive();
    req[c] = '0;
  endtask

  // two word block with requester and peer stepping together
  task automatic run_data(input int c, input logic rd, input logic wr, input logic cw,
                          input mem_types_pkg::word_t a0, input mem_types_pkg::word_t a1,
                          input mem_types_pkg::word_t d0, input mem_types_pkg::word_t d1,
                          input logic pcw, input mem_types_pkg::word_t p0,
                          input mem_types_pkg::word_t p1,
                          output mem_types_pkg::word_t got0, output mem_types_pkg::word_t got1);
    snoop_seen     = 1'b0;
    inv_seen       = 1'b0;
    snoop_first    = '0;
    req[c].dren    = rd;
    req[c].dwen    = wr;
    req[c].ccwrite = cw;
    req[c].daddr   = a0;
    req[c].dstore  = d0;
    req[1-c].ccwrite = pcw;
    req[1-c].dstore  = p0;
    wait_dwait_low(c);
    got0 = rsp[c].dload;
    next_drive();
    req[c].daddr    = a1;
    req[c].dstore   = d1;
    req[1-c].dstore = p1;
    wait_dwait_low(c);
    got1 = rsp[c].dload;
    next_drive();
    req = '0;
  endtask

  task automatic run_trans(input int t, input mem_types_pkg::word_t a0,
                           input mem_types_pkg::word_t a1, input mem_types_pkg::word_t e0);
    req[t].cctrans = 1'b1;
    req[t].daddr   = a0;
    req[1-t].iren  = 1'b1;
    req[1-t].iaddr = a1;
    // transition not latched yet in this cycle
    @(negedge CLK);
    repeat (TRANS_HOLD) begin
      @(negedge CLK);
      check_flag({test_name, " waits"}, 1'b1,
                 rsp[0].iwait & rsp[0].dwait & rsp[1].iwait & rsp[1].dwait);
      check_flag({test_name, " peer ccwait"}, 1'b1, rsp[1-t].ccwait);
      check_flag({test_name, " peer ccinv"}, 1'b1, rsp[1-t].ccinv);
      check_word({test_name, " peer ccsnoopaddr"}, a0, rsp[1-t].ccsnoopaddr);
    end
    next_drive();
    req[t] = '0;
    wait_iwait_low(1 - t);
    check_word({test_name, " iload"}, e0, rsp[1-t].iload);
    next_drive();
    req = '0;
  endtask

  task automatic run_both(input mem_types_pkg::word_t a0, input mem_types_pkg::word_t a1,
                          input mem_types_pkg::word_t e0, input mem_types_pkg::word_t e1);
    apply_reset();
    req[0].iren  = 1'b1;
    req[0].iaddr = a0;
    req[1].iren  = 1'b1;
    req[1].iaddr = a1;
    wait_any_iwait();
    // arbitration starts at core 0
    check_flag({test_name, " core 0 iwait"}, 1'b0, rsp[0].iwait);
    check_flag({test_name, " core 1 iwait"}, 1'b1, rsp[1].iwait);
    check_word({test_name, " core 0 iload"}, e0, rsp[0].iload);
    next_drive();
    req[0] = '0;
    wait_iwait_low(1);
    check_word({test_name, " core 1 iload"}, e1, rsp[1].iload);
    next_drive();
    req = '0;
  endtask

  task automatic run_line(input logic [79:0] op, input int c,
                          input mem_types_pkg::word_t a0, input mem_types_pkg::word_t a1,
                          input mem_types_pkg::word_t d0, input mem_types_pkg::word_t d1,
                          input logic pcw, input mem_types_pkg::word_t p0,
                          input mem_types_pkg::word_t p1,
                          input mem_types_pkg::word_t e0, input mem_types_pkg::word_t e1);
    mem_types_pkg::word_t g0;
    mem_types_pkg::word_t g1;
    if (op == "FETCH") begin
      run_fetch(c, a0, g0);
      check_word({test_name, " iload"}, e0, g0);
    end else if (op == "WRITEBACK") begin
      run_data(c, 1'b0, 1'b1, 1'b0, a0, a1, d0, d1, 1'b0, '0, '0, g0, g1);
      check_flag({test_name, " peer ccinv"}, 1'b1, inv_seen);
    end else if (op == "READ" || op == "WRITEMISS") begin
      run_data(c, op == "READ", op == "WRITEMISS", op == "WRITEMISS",
               a0, a1, d0, d1, pcw, p0, p1, g0, g1);
      check_word({test_name, " dload 0"}, e0, g0);
      check_word({test_name, " dload 1"}, e1, g1);
      // only a write miss invalidates the peer
      check_flag({test_name, " peer ccinv"}, op == "WRITEMISS", inv_seen);
      if (pcw) begin
        check_flag({test_name, " peer ccwait"}, 1'b1, snoop_seen);
        check_word({test_name, " peer ccsnoopaddr"}, a0, snoop_first);
      end
    end else if (op == "BOTH") begin
      run_both(a0, a1, e0, e1);
    end else if (op == "TRANS") begin
      run_trans(c, a0, a1, e0);
    end else begin
      $display("%s: unknown operation in mem_stimulus.txt", test_name);
      $display("** FAIL **");
      $fatal(1, "bad stimulus line");
    end
    // idle gap between operations
    next_drive();
    next_drive();
  endtask

  initial begin
    int fd;
    int n;
    int lines_run;
    int c;
    string line;
    logic [79:0] op;
    mem_types_pkg::word_t a0;
    mem_types_pkg::word_t a1;
    mem_types_pkg::word_t d0;
    mem_types_pkg::word_t d1;
    mem_types_pkg::word_t pcw;
    mem_types_pkg::word_t p0;
    mem_types_pkg::word_t p1;
    mem_types_pkg::word_t e0;
    mem_types_pkg::word_t e1;
    nRST      = 1'b0;
    req       = '0;
    lines_run = 0;
    apply_reset();
    fd = $fopen("mem_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open mem_stimulus.txt");
      $display("** FAIL **");
      $fatal(1, "no stimulus file");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      n = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h",
                  op, c, a0, a1, d0, d1, pcw, p0, p1, e0, e1);
      // comment and blank lines do not scan all fields
      if (n == 11) begin
        lines_run++;
        test_name = $sformatf("op %0d %0s", lines_run, op);
        run_line(op, c, a0, a1, d0, d1, pcw[0], p0, p1, e0, e1);
      end
    end
    $fclose(fd);
    if (lines_run == 0) begin
      $display("no operations found in mem_stimulus.txt");
      $display("** FAIL **");
      $fatal(1, "empty stimulus");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

  `include "tb_checks.svh"

endmodule

`default_nettype wire

// ==== mem_stimulus.txt ====
# op core addr0 addr1 store0 store1 peer_ccwrite peer_store0 peer_store1 expect0 expect1
# core is decimal, all other fields hex; BOTH fetches addr0 on core 0 and addr1 on core 1
# TRANS: core holds cctrans with daddr addr0 while the other core fetches addr1
WRITEBACK 0 100 104 11110000 11110004 0 0 0 0 0
FETCH     1 100 0 0 0 0 0 0 11110000 0
READ      1 100 104 0 0 0 0 0 11110000 11110004
WRITEBACK 1 200 204 22220000 22220004 0 0 0 0 0
READ      0 200 204 0 0 1 aaaa0000 aaaa0004 aaaa0000 aaaa0004
READ      1 200 204 0 0 0 0 0 aaaa0000 aaaa0004
WRITEBACK 0 300 304 33330000 33330004 0 0 0 0 0
WRITEMISS 0 300 304 0 0 1 bbbb0000 bbbb0004 bbbb0000 bbbb0004
READ      1 300 304 0 0 0 0 0 33330000 33330004
WRITEMISS 1 100 104 0 0 0 0 0 11110000 11110004
WRITEBACK 1 040 044 44440000 44440004 0 0 0 0 0
BOTH      0 040 044 0 0 0 0 0 44440000 44440004
TRANS     0 3c0 100 0 0 0 0 0 11110000 0
TRANS     1 3c4 204 0 0 0 0 0 aaaa0004 0
FETCH     0 204 0 0 0 0 0 0 aaaa0004 0
FETCH     1 044 0 0 0 0 0 0 44440004 0

// ==== compile.f ====
+incdir+.
mem_types_pkg.sv
main_ram.sv
memory_control.sv
memory_subsystem.sv
tb_memory_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench; the exit status is the simulation result
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_memory_subsystem -f compile.f
./obj_dir/Vtb_memory_subsystem
